// File: rtl/sp_pkg.sv
package sp_pkg;

   localparam logic [7:0] REGION_BRIDGE = 8'h80; // 32-to-8 byte bridge.
   localparam logic [7:0] REGION_MMIO   = 8'hff; // register block.

   // region view: top byte selects the slave.
   typedef struct packed {
      logic [7:0]  region;
      logic [23:0] offset;
   } sp_region_t;

   // word view: index into a word array plus byte lane.
   typedef struct packed {
      logic [29:0] index;
      logic [1:0]  lane;
   } sp_word_t;

   typedef union packed {
      sp_region_t rgn;
      sp_word_t   word;
   } sp_addr_u;

   // master request, byte select 0 is the most significant byte.
   typedef struct packed {
      sp_addr_u    adr;
      logic [31:0] dat;
      logic [0:3]  sel;
      logic        we;
   } sp_req_t;

   typedef struct packed {
      logic [31:0] dat;
      logic        ack;
   } sp_rsp_t;

   // one byte cycle on the narrow bus.
   typedef struct packed {
      logic [23:0] adr;
      logic [7:0]  dat;
      logic        we;
      logic        sel;
   } nb_req_t;

endpackage

// File: rtl/sp_bus_ctrl.sv
`timescale 1ns/1ns

module sp_bus_ctrl import sp_pkg::*; (
   input  logic    clk,
   input  logic    reset_i,
   input  logic    m_cyc_i,
   input  logic    m_stb_i,
   input  sp_req_t m_req_i,
   output sp_rsp_t m_rsp_o,
   input  sp_rsp_t mem_rsp_i,
   input  sp_rsp_t mmio_rsp_i,
   input  sp_rsp_t br_rsp_i,
   output logic    mem_stb_o,
   output logic    mmio_stb_o,
   output logic    br_stb_o,
   output logic    br_cyc_o
);

   logic       access;
   logic       is_mem;
   logic       is_mmio;
   logic       is_br;
   logic       is_none;
   logic [7:0] region;
   logic       none_ack_q;

   assign access = m_cyc_i && m_stb_i;
   assign region = m_req_i.adr.rgn.region;

   assign is_mem  = !region[7]; // top bit clear.
   assign is_br   = (region == REGION_BRIDGE);
   assign is_mmio = (region == REGION_MMIO);
   assign is_none = !is_mem && !is_br && !is_mmio;

   assign mem_stb_o  = access && is_mem;
   assign mmio_stb_o = access && is_mmio;
   assign br_stb_o   = access && is_br;
   assign br_cyc_o   = m_cyc_i && is_br;

   // unmapped accesses complete here so the master never hangs.
   always_ff @(posedge clk) begin
      if (reset_i || none_ack_q) begin
         none_ack_q <= 1'b0; // one ack per access.
      end else if (access && is_none) begin
         none_ack_q <= 1'b1;
      end
   end

   always_comb begin
      m_rsp_o.ack = mem_rsp_i.ack | mmio_rsp_i.ack | br_rsp_i.ack | none_ack_q;
      if (is_mmio) begin
         m_rsp_o.dat = mmio_rsp_i.dat;
      end else if (is_br) begin
         m_rsp_o.dat = br_rsp_i.dat;
      end else if (is_mem) begin
         m_rsp_o.dat = mem_rsp_i.dat;
      end else begin
         m_rsp_o.dat = 32'd0; // unmapped reads as zero.
      end
   end

   // a slave must not answer a master that is not asking.
   ack_needs_stb: assert property (@(posedge clk) disable iff (reset_i)
      m_rsp_o.ack |-> (m_cyc_i && m_stb_i))
      else $error("master ack without strobe");

endmodule

// File: rtl/sp_mem.sv
`timescale 1ns/1ns

module sp_mem import sp_pkg::*; #(
   parameter int MEM_WORDS = 256
) (
   input  logic    clk,
   input  logic    reset_i,
   input  logic    stb_i,
   input  sp_req_t req_i,
   output sp_rsp_t rsp_o
);

   localparam int AW = $clog2(MEM_WORDS);

   logic [31:0]   ram [MEM_WORDS];
   logic [AW-1:0] idx;
   logic          accept;
   logic          ack_q;
   logic [31:0]   rd_q;

   assign idx    = req_i.adr.word.index[AW-1:0]; // wraps modulo depth.
   assign accept = stb_i && !ack_q;

   always_ff @(posedge clk) begin
      if (reset_i || ack_q) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= stb_i;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rd_q <= ram[idx]; // old contents on a write.
         if (req_i.we) begin
            for (int k = 0; k < 4; k++) begin
               if (req_i.sel[k]) begin
                  ram[idx][31-8*k -: 8] <= req_i.dat[31-8*k -: 8];
               end
            end
         end
      end
   end

   assign rsp_o = '{dat: rd_q, ack: ack_q};

   single_ack: assert property (@(posedge clk) disable iff (reset_i)
      ack_q |=> !ack_q)
      else $error("memory ack held for two cycles");

endmodule

// File: rtl/sp_mmio.sv
`timescale 1ns/1ns

module sp_mmio import sp_pkg::*; (
   input  logic       clk,
   input  logic       reset_i,
   input  logic       stb_i,
   input  sp_req_t    req_i,
   output sp_rsp_t    rsp_o,
   output logic [1:0] led_o,
   output logic [4:0] sw_reset_o,
   input  logic       keypress_i,
   input  logic [6:0] keycode_i
);

   logic [21:0] word;
   logic        accept;
   logic        wr;
   logic        key_rd;
   logic        ack_q;
   logic [31:0] rd_q;
   logic [31:0] rd_word;
   logic [1:0]  led_q;
   logic [4:0]  sw_reset_q;
   logic        key_valid_q;
   logic [6:0]  key_code_q;
   logic [31:0] scratch_q;

   assign word   = req_i.adr.rgn.offset[23:2];
   assign accept = stb_i && !ack_q;
   assign wr     = accept && req_i.we;
   assign key_rd = accept && !req_i.we && (word == 22'd2);

   always_ff @(posedge clk) begin
      if (reset_i || ack_q) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= stb_i;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         led_q       <= 2'b00;
         sw_reset_q  <= 5'd0;
         key_valid_q <= 1'b0;
      end else begin
         if (wr && word == 22'd0 && req_i.sel[0]) begin
            led_q <= req_i.dat[31:30];
         end
         // pulse lands in the cycle after the ack.
         sw_reset_q <= (ack_q && stb_i && req_i.we && word == 22'd1) ? req_i.dat[4:0] : 5'd0;
         if (keypress_i) begin
            key_valid_q <= 1'b1; // new key beats the read clear.
         end else if (key_rd) begin
            key_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (keypress_i) begin
         key_code_q <= keycode_i;
      end
      if (wr && word == 22'd3) begin
         for (int k = 0; k < 4; k++) begin
            if (req_i.sel[k]) begin
               scratch_q[31-8*k -: 8] <= req_i.dat[31-8*k -: 8];
            end
         end
      end
      if (accept) begin
         rd_q <= rd_word;
      end
   end

   always_comb begin
      case (word)
         22'd0:   rd_word = {led_q, 30'd0};
         22'd2:   rd_word = key_valid_q ? {1'b1, 24'd0, key_code_q} : 32'd0;
         22'd3:   rd_word = scratch_q;
         default: rd_word = 32'd0; // reset word and unused space.
      endcase
   end

   assign rsp_o      = '{dat: rd_q, ack: ack_q};
   assign led_o      = led_q; // green on bit 1, red on bit 0.
   assign sw_reset_o = sw_reset_q;

   sw_reset_pulse: assert property (@(posedge clk) disable iff (reset_i)
      (sw_reset_o != 5'd0) |=> (sw_reset_o == 5'd0))
      else $error("software reset longer than one cycle");

endmodule

// File: rtl/sp_byte_bridge.sv
`timescale 1ns/1ns

module sp_byte_bridge import sp_pkg::*; (
   input  logic       clk,
   input  logic       reset_i,
   input  logic       cyc_i,
   input  logic       stb_i,
   input  sp_req_t    req_i,
   output sp_rsp_t    rsp_o,
   output logic       nb_cyc_o,
   output logic       nb_stb_o,
   output nb_req_t    nb_req_o,
   input  logic       nb_ack_i,
   input  logic [7:0] nb_dat_i
);

   logic [1:0]       sub_q;
   logic [31:0]      shift_q;
   logic             done_q;
   logic [3:0][7:0]  wr_bytes;

   assign wr_bytes = req_i.dat; // element 3 holds byte lane 0.

   assign nb_cyc_o = cyc_i;
   assign nb_stb_o = stb_i && !done_q; // drops with the master ack.

   always_comb begin
      nb_req_o.adr = {req_i.adr.word.index[21:0], sub_q};
      nb_req_o.dat = wr_bytes[~sub_q];
      nb_req_o.we  = req_i.we;
      nb_req_o.sel = req_i.sel[sub_q];
   end

   always_ff @(posedge clk) begin
      if (reset_i || done_q || !cyc_i || !stb_i) begin
         done_q <= 1'b0;
         sub_q  <= 2'd0;
      end else if (nb_ack_i) begin
         if (sub_q == 2'd3) begin
            done_q <= 1'b1; // last byte seen.
         end
         sub_q <= sub_q + 2'd1;
      end
   end

   // first byte read ends up in the top lane.
   always_ff @(posedge clk) begin
      if (nb_stb_o && nb_ack_i) begin
         shift_q <= {shift_q[23:0], nb_dat_i};
      end
   end

   assign rsp_o = '{dat: shift_q, ack: done_q};

   nb_req_stable: assert property (@(posedge clk) disable iff (reset_i)
      (nb_stb_o && !nb_ack_i) |=> $stable(nb_req_o))
      else $error("narrow request changed while waiting for ack");

endmodule

// File: rtl/sp_fabric.sv
`timescale 1ns/1ns

module sp_fabric import sp_pkg::*; #(
   parameter int MEM_WORDS = 256
) (
   input  logic       clk,
   input  logic       reset_i,
   input  logic       m_cyc_i,
   input  logic       m_stb_i,
   input  sp_req_t    m_req_i,
   output sp_rsp_t    m_rsp_o,
   output logic       nb_cyc_o,
   output logic       nb_stb_o,
   output nb_req_t    nb_req_o,
   input  logic       nb_ack_i,
   input  logic [7:0] nb_dat_i,
   output logic [1:0] led_o,
   output logic [4:0] sw_reset_o,
   input  logic       keypress_i,
   input  logic [6:0] keycode_i
);

   logic    mem_stb;
   logic    mmio_stb;
   logic    br_stb;
   logic    br_cyc;
   sp_rsp_t mem_rsp;
   sp_rsp_t mmio_rsp;
   sp_rsp_t br_rsp;

   sp_bus_ctrl u_ctrl (
      .clk(clk), .reset_i(reset_i),
      .m_cyc_i(m_cyc_i), .m_stb_i(m_stb_i), .m_req_i(m_req_i), .m_rsp_o(m_rsp_o),
      .mem_rsp_i(mem_rsp), .mmio_rsp_i(mmio_rsp), .br_rsp_i(br_rsp),
      .mem_stb_o(mem_stb), .mmio_stb_o(mmio_stb),
      .br_stb_o(br_stb), .br_cyc_o(br_cyc));

   sp_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
      .clk(clk), .reset_i(reset_i),
      .stb_i(mem_stb), .req_i(m_req_i), .rsp_o(mem_rsp));

   sp_mmio u_mmio (
      .clk(clk), .reset_i(reset_i),
      .stb_i(mmio_stb), .req_i(m_req_i), .rsp_o(mmio_rsp),
      .led_o(led_o), .sw_reset_o(sw_reset_o),
      .keypress_i(keypress_i), .keycode_i(keycode_i));

   sp_byte_bridge u_bridge (
      .clk(clk), .reset_i(reset_i),
      .cyc_i(br_cyc), .stb_i(br_stb), .req_i(m_req_i), .rsp_o(br_rsp),
      .nb_cyc_o(nb_cyc_o), .nb_stb_o(nb_stb_o), .nb_req_o(nb_req_o),
      .nb_ack_i(nb_ack_i), .nb_dat_i(nb_dat_i));

endmodule

// File: sim/byte_bus_model.sv
`timescale 1ns/1ns

module byte_bus_model import sp_pkg::*; (
   input  logic       clk,
   input  logic       reset_i,
   input  logic       cyc_i,
   input  logic       stb_i,
   input  nb_req_t    req_i,
   output logic       ack_o,
   output logic [7:0] dat_o
);

   logic [7:0] mem [256];
   logic [23:0] last_adr; // address of the last acked byte.
   integer     seed = 85787;
   logic       busy_q;
   int         wait_q;
   int         delay;

   // every address gets a different preload byte.
   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[8'(i)] = 8'((i * 37) ^ 93);
      end
   end

   always @(posedge clk) begin
      if (reset_i) begin
         ack_o  <= 1'b0;
         dat_o  <= 8'd0;
         busy_q <= 1'b0;
         wait_q <= 0;
      end else if (ack_o) begin
         ack_o <= 1'b0; // bridge moves on to the next byte.
      end else if (cyc_i && stb_i) begin
         if (busy_q) begin
            delay = wait_q;
         end else begin
            delay = $random(seed) & 3; // 0 to 3 wait cycles.
         end
         if (delay == 0) begin
            ack_o    <= 1'b1;
            busy_q   <= 1'b0;
            dat_o    <= mem[req_i.adr[7:0]];
            last_adr <= req_i.adr;
            if (req_i.we && req_i.sel) begin
               mem[req_i.adr[7:0]] <= req_i.dat;
            end
         end else begin
            busy_q <= 1'b1;
            wait_q <= delay - 1;
         end
      end
   end

endmodule

// File: sim/sp_fabric_tb.sv
`timescale 1ns/1ns

module sp_fabric_tb import sp_pkg::*; ();

   localparam int MEM_WORDS   = 256;
   localparam int AW          = $clog2(MEM_WORDS);
   localparam int ACK_TIMEOUT = 100; // cycles, well above the slowest bridge access.

   logic        clk;
   logic        reset;
   logic        m_cyc;
   logic        m_stb;
   sp_req_t     m_req;
   sp_rsp_t     m_rsp;
   logic        nb_cyc;
   logic        nb_stb;
   nb_req_t     nb_req;
   logic        nb_ack;
   logic [7:0]  nb_dat;
   logic [1:0]  led;
   logic [4:0]  sw_reset;
   logic        keypress;
   logic [6:0]  keycode;
   logic [31:0] mem_ref [MEM_WORDS];

   sp_fabric #(.MEM_WORDS(MEM_WORDS)) DUT (
      .clk(clk), .reset_i(reset),
      .m_cyc_i(m_cyc), .m_stb_i(m_stb), .m_req_i(m_req), .m_rsp_o(m_rsp),
      .nb_cyc_o(nb_cyc), .nb_stb_o(nb_stb), .nb_req_o(nb_req),
      .nb_ack_i(nb_ack), .nb_dat_i(nb_dat),
      .led_o(led), .sw_reset_o(sw_reset),
      .keypress_i(keypress), .keycode_i(keycode));

   byte_bus_model nb_model (
      .clk(clk), .reset_i(reset),
      .cyc_i(nb_cyc), .stb_i(nb_stb), .req_i(nb_req),
      .ack_o(nb_ack), .dat_o(nb_dat));

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Verification failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check(input string test, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         fail_run($sformatf("ERR %s expected %h actual %h", test, expected, actual));
      end
   endtask

   task automatic master_cycle(input logic [31:0] adr, input logic [31:0] dat,
                               input logic [3:0] sel, input logic we,
                               output logic [31:0] rdat);
      int waited;
      waited = 0;
      @(posedge clk);
      m_cyc     <= 1'b1;
      m_stb     <= 1'b1;
      m_req.adr <= adr;
      m_req.dat <= dat;
      m_req.sel <= sel; // sel[3] lands on byte select 0.
      m_req.we  <= we;
      @(negedge clk);
      while (m_rsp.ack !== 1'b1 && waited < ACK_TIMEOUT) begin
         waited++;
         @(negedge clk);
      end
      if (m_rsp.ack !== 1'b1) begin
         fail_run($sformatf("timeout: no master ack for address %h", adr));
      end
      rdat = m_rsp.dat;
      @(posedge clk);
      m_cyc <= 1'b0;
      m_stb <= 1'b0;
   endtask

   task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
      logic [31:0] unused_rd;
      master_cycle(adr, dat, sel, 1'b1, unused_rd);
   endtask

   task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdat);
      master_cycle(adr, 32'd0, 4'b1111, 1'b0, rdat);
   endtask

   // bit 3 of sel covers the most significant byte.
   function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0] sel);
      logic [31:0] mask;
      mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
      return (new_word & mask) | (old_word & ~mask);
   endfunction

   // four model bytes, lowest address in the top lane.
   function automatic logic [31:0] model_word(input logic [7:0] a);
      return {nb_model.mem[a], nb_model.mem[a + 8'd1],
              nb_model.mem[a + 8'd2], nb_model.mem[a + 8'd3]};
   endfunction

   task automatic mem_store(input logic [29:0] index, input logic [31:0] dat,
                            input logic [3:0] sel);
      bus_write({index, 2'b00}, dat, sel);
      mem_ref[index[AW-1:0]] = merge_lanes(mem_ref[index[AW-1:0]], dat, sel);
   endtask

   task automatic mem_load(input string test, input logic [29:0] index);
      logic [31:0] rd;
      bus_read({index, 2'b00}, rd);
      check(test, mem_ref[index[AW-1:0]], rd);
   endtask

   task automatic press_key(input logic [6:0] code);
      @(posedge clk);
      keypress <= 1'b1;
      keycode  <= code;
      @(posedge clk);
      keypress <= 1'b0;
   endtask

   task automatic test_mem();
      mem_store(30'd0, 32'h0123_4567, 4'b1111);
      mem_store(30'd1, 32'h89ab_cdef, 4'b1111);
      mem_store(30'd5, 32'h5555_aaaa, 4'b1111);
      mem_store(30'd100, 32'h1357_9bdf, 4'b1111);
      mem_store(30'(MEM_WORDS - 1), 32'hfedc_ba98, 4'b1111);
      mem_store(30'd1, 32'hdead_beef, 4'b0011);
      mem_store(30'd100, 32'h0bad_cafe, 4'b1100);
      mem_store(30'(MEM_WORDS - 1), 32'h7777_7777, 4'b0100);
      mem_store(30'(MEM_WORDS + 5), 32'hcafe_f00d, 4'b1001); // aliases word 5.
      mem_load("test_mem", 30'd0);
      mem_load("test_mem", 30'd1);
      mem_load("test_mem", 30'd5);
      mem_load("test_mem", 30'd100);
      mem_load("test_mem", 30'(MEM_WORDS - 1));
      mem_load("test_mem", 30'(2 * MEM_WORDS - 1));
   endtask

   task automatic test_bridge();
      logic [31:0] rd;
      logic [31:0] merged;
      @(negedge clk);
      check("test_bridge", 32'd0, {30'd0, nb_cyc, nb_stb});
      bus_write(32'h8000_0010, 32'ha1b2_c3d4, 4'b1111);
      check("test_bridge", 32'ha1b2_c3d4, model_word(8'h10));
      bus_write(32'h8012_34fc, 32'h0f1e_2d3c, 4'b1111);
      check("test_bridge", 32'h0f1e_2d3c, model_word(8'hfc));
      check("test_bridge", 32'h0012_34ff, 32'(nb_model.last_adr)); // full narrow address.
      merged = merge_lanes(model_word(8'h20), 32'h1122_3344, 4'b0101);
      bus_write(32'h8000_0020, 32'h1122_3344, 4'b0101);
      check("test_bridge", merged, model_word(8'h20));
      bus_read(32'h8000_0010, rd);
      check("test_bridge", 32'ha1b2_c3d4, rd);
      bus_read(32'h8012_34fc, rd);
      check("test_bridge", 32'h0f1e_2d3c, rd);
      bus_read(32'h8000_0020, rd);
      check("test_bridge", merged, rd);
      bus_read(32'h8000_0080, rd);
      check("test_bridge", model_word(8'h80), rd); // untouched preload.
   endtask

   task automatic test_mmio_regs();
      logic [31:0] rd;
      logic [31:0] scratch;
      @(negedge clk);
      check("test_mmio_regs", 32'd0, 32'(led));
      bus_write(32'hff00_0000, 32'hc000_0000, 4'b1000);
      @(negedge clk);
      check("test_mmio_regs", 32'd3, 32'(led));
      bus_write(32'hff00_0000, 32'h0000_0000, 4'b0111); // top lane not selected.
      @(negedge clk);
      check("test_mmio_regs", 32'd3, 32'(led));
      bus_write(32'hff00_0000, 32'h8000_0000, 4'b1000);
      @(negedge clk);
      check("test_mmio_regs", 32'd2, 32'(led)); // green on, red off.
      bus_read(32'hff00_0000, rd);
      check("test_mmio_regs", 32'h8000_0000, rd);
      scratch = 32'h1122_3344;
      bus_write(32'hff00_000c, scratch, 4'b1111);
      bus_write(32'hff00_000c, 32'haabb_ccdd, 4'b0101);
      scratch = merge_lanes(scratch, 32'haabb_ccdd, 4'b0101);
      bus_read(32'hff00_000c, rd);
      check("test_mmio_regs", scratch, rd);
      bus_read(32'hff00_0004, rd);
      check("test_mmio_regs", 32'd0, rd);
      bus_read(32'hff00_0010, rd);
      check("test_mmio_regs", 32'd0, rd);
      bus_read(32'hff80_0000, rd);
      check("test_mmio_regs", 32'd0, rd);
   endtask

   task automatic test_sw_reset();
      logic [31:0] wr_word;
      wr_word = 32'h5a5a_5a75;
      @(negedge clk);
      check("test_sw_reset", 32'd0, 32'(sw_reset));
      bus_write(32'hff00_0004, wr_word, 4'b1111);
      @(negedge clk);
      check("test_sw_reset", 32'(wr_word[4:0]), 32'(sw_reset)); // cycle after the ack.
      @(negedge clk);
      check("test_sw_reset", 32'd0, 32'(sw_reset));
      @(negedge clk);
      check("test_sw_reset", 32'd0, 32'(sw_reset));
   endtask

   task automatic test_keys();
      logic [31:0] rd;
      bus_read(32'hff00_0008, rd);
      check("test_keys", 32'd0, rd); // nothing pressed since reset.
      press_key(7'h2a);
      bus_read(32'hff00_0008, rd);
      check("test_keys", {1'b1, 24'd0, 7'h2a}, rd);
      bus_read(32'hff00_0008, rd);
      check("test_keys", 32'd0, rd);
      press_key(7'h51);
      press_key(7'h13);
      bus_read(32'hff00_0008, rd);
      check("test_keys", {1'b1, 24'd0, 7'h13}, rd);
   endtask

   // any region with the top bit clear is local memory.
   task automatic test_unmapped();
      logic [31:0] rd;
      mem_store(30'd4, 32'h600d_f00d, 4'b1111);
      bus_read(32'hc000_0000, rd);
      check("test_unmapped", 32'd0, rd);
      bus_read(32'h8100_0010, rd);
      check("test_unmapped", 32'd0, rd);
      bus_write(32'hc000_0010, 32'hbad0_bad0, 4'b1111); // same offset as word 4.
      bus_write(32'hfe00_0010, 32'hbad1_bad1, 4'b1111);
      mem_load("test_unmapped", 30'd4);
   endtask

   initial begin
      reset    = 1'b1;
      m_cyc    = 1'b0;
      m_stb    = 1'b0;
      m_req    = '0;
      keypress = 1'b0;
      keycode  = 7'd0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      test_mem();
      test_bridge();
      test_mmio_regs();
      test_sw_reset();
      test_keys();
      test_unmapped();
      $display("Verification passed");
      $finish;
   end

endmodule

// File: sources.f
rtl/sp_pkg.sv
rtl/sp_bus_ctrl.sv
rtl/sp_mem.sv
rtl/sp_mmio.sv
rtl/sp_byte_bridge.sv
rtl/sp_fabric.sv
sim/byte_bus_model.sv
sim/sp_fabric_tb.sv

// File: Makefile
TOP = sp_fabric_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f sources.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
